//--- design/eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam int BLK_W  = 3;     // address bits 10:8 travel in the control byte

    typedef logic [ADDR_W-1:0] eeprom_addr_t;
    typedef logic [DATA_W-1:0] eeprom_data_t;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;
    localparam logic       RW_WRITE    = 1'b0;
    localparam logic       RW_READ     = 1'b1;

    // one bus bit is SCL_PHASES clocks
    localparam int SCL_PHASES = 4;
    localparam int PHASE_W    = $clog2(SCL_PHASES);

    typedef logic [PHASE_W-1:0]         phase_t;
    typedef logic [$clog2(DATA_W)-1:0]  bit_cnt_t;

    localparam phase_t PH_SCL_FALL = phase_t'(0);
    localparam phase_t PH_SDA_SET  = phase_t'(1);   // middle of scl low
    localparam phase_t PH_SCL_RISE = phase_t'(2);
    localparam phase_t PH_SAMPLE   = phase_t'(SCL_PHASES - 1);

    typedef struct packed {
        logic         is_read;
        eeprom_addr_t addr;
        eeprom_data_t wdata;
    } eeprom_cmd_t;

    // device code, block bits, r/w bit
    function automatic eeprom_data_t ctrl_byte(eeprom_addr_t addr, logic rw);
        return {DEVICE_CODE, addr[ADDR_W-1 -: BLK_W], rw};
    endfunction

endpackage

//--- design/eeprom_ctrl_pkg.sv
package eeprom_ctrl_pkg;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } byte_op_e;

    typedef struct packed {
        byte_op_e                     op;
        eeprom_bus_pkg::eeprom_data_t tx_byte;
        logic                         last;     // nack the byte on a read
    } byte_cmd_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_CTRL_W, ST_ADDR, ST_DATA_W,
        ST_RESTART, ST_CTRL_R, ST_DATA_R, ST_STOP, ST_DONE
    } seq_state_e;

    typedef enum logic [2:0] {
        EN_IDLE,
        EN_START,
        EN_BITS,
        EN_ACK,
        EN_STOP
    } engine_state_e;

endpackage

//--- design/eeprom_cmd_latch.sv
`timescale 1ns/1ps

module eeprom_cmd_latch (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         wr,
    input  logic                         rd,
    input  eeprom_bus_pkg::eeprom_addr_t addr,
    input  eeprom_bus_pkg::eeprom_data_t wdata,
    input  logic                         cmd_done,
    output eeprom_bus_pkg::eeprom_cmd_t  cmd,
    output logic                         cmd_valid
);

    logic take;

    // strobes only land while empty
    assign take = (wr | rd) & ~cmd_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cmd_valid <= 1'b0;
        end
        else if (take)
        begin
            cmd_valid <= 1'b1;
        end
        else if (cmd_done)
        begin
            cmd_valid <= 1'b0;
        end
    end

    // held for the whole transaction
    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            cmd.is_read <= ~wr;     // wr wins
            cmd.addr    <= addr;
            cmd.wdata   <= wdata;
        end
    end

endmodule

//--- design/i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine (
    input  logic                         CLK,
    input  logic                         RESET,
    input  eeprom_ctrl_pkg::byte_cmd_t   byte_cmd,
    input  logic                         byte_go,
    output logic                         byte_busy,
    output logic                         byte_done,
    output logic                         ack_seen,
    output eeprom_bus_pkg::eeprom_data_t rx_byte,
    output logic                         scl,
    output logic                         sda_low,
    input  logic                         sda_in
);

    eeprom_ctrl_pkg::engine_state_e state;
    eeprom_bus_pkg::phase_t         phase;
    eeprom_bus_pkg::bit_cnt_t       bit_cnt;
    eeprom_bus_pkg::eeprom_data_t   shreg;
    logic                           rd_mode;
    logic                           last_q;

    assign byte_busy = (state != eeprom_ctrl_pkg::EN_IDLE);
    assign rx_byte   = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_ctrl_pkg::EN_IDLE;
            phase     <= eeprom_bus_pkg::PH_SCL_FALL;
            bit_cnt   <= '0;
            scl       <= 1'b1;
            sda_low   <= 1'b0;
            byte_done <= 1'b0;
            ack_seen  <= 1'b0;
            rd_mode   <= 1'b0;
            last_q    <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            phase     <= phase + 1'b1;     // wraps every bus bit
            case (state)
                eeprom_ctrl_pkg::EN_IDLE:
                begin
                    phase <= eeprom_bus_pkg::PH_SCL_FALL;
                    if (byte_go)
                    begin
                        // go cycle doubles as phase 0, scl low for every op
                        scl     <= 1'b0;
                        phase   <= eeprom_bus_pkg::PH_SDA_SET;
                        bit_cnt <= '0;
                        rd_mode <= (byte_cmd.op == eeprom_ctrl_pkg::OP_READ);
                        last_q  <= byte_cmd.last;
                        case (byte_cmd.op)
                            eeprom_ctrl_pkg::OP_START: state <= eeprom_ctrl_pkg::EN_START;
                            eeprom_ctrl_pkg::OP_STOP:  state <= eeprom_ctrl_pkg::EN_STOP;
                            default:                   state <= eeprom_ctrl_pkg::EN_BITS;
                        endcase
                    end
                end
                eeprom_ctrl_pkg::EN_START:
                begin
                    case (phase)
                        eeprom_bus_pkg::PH_SDA_SET:  sda_low <= 1'b0;  // matters for restart
                        eeprom_bus_pkg::PH_SCL_RISE: scl <= 1'b1;
                        eeprom_bus_pkg::PH_SAMPLE:
                        begin
                            sda_low   <= 1'b1;     // start edge
                            byte_done <= 1'b1;
                            state     <= eeprom_ctrl_pkg::EN_IDLE;
                        end
                        default: ;
                    endcase
                end
                eeprom_ctrl_pkg::EN_STOP:
                begin
                    case (phase)
                        eeprom_bus_pkg::PH_SDA_SET:  sda_low <= 1'b1;
                        eeprom_bus_pkg::PH_SCL_RISE: scl <= 1'b1;
                        eeprom_bus_pkg::PH_SAMPLE:
                        begin
                            sda_low   <= 1'b0;     // stop edge, bus idle after
                            byte_done <= 1'b1;
                            state     <= eeprom_ctrl_pkg::EN_IDLE;
                        end
                        default: ;
                    endcase
                end
                eeprom_ctrl_pkg::EN_BITS:
                begin
                    case (phase)
                        eeprom_bus_pkg::PH_SCL_FALL: scl <= 1'b0;
                        eeprom_bus_pkg::PH_SDA_SET:  sda_low <= ~rd_mode & ~shreg[7];
                        eeprom_bus_pkg::PH_SCL_RISE: scl <= 1'b1;
                        eeprom_bus_pkg::PH_SAMPLE:
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == eeprom_bus_pkg::bit_cnt_t'(eeprom_bus_pkg::DATA_W - 1))
                            begin
                                state <= eeprom_ctrl_pkg::EN_ACK;
                            end
                        end
                        default: ;
                    endcase
                end
                eeprom_ctrl_pkg::EN_ACK:
                begin
                    case (phase)
                        eeprom_bus_pkg::PH_SCL_FALL: scl <= 1'b0;
                        eeprom_bus_pkg::PH_SDA_SET:  sda_low <= rd_mode & ~last_q;
                        eeprom_bus_pkg::PH_SCL_RISE: scl <= 1'b1;
                        eeprom_bus_pkg::PH_SAMPLE:
                        begin
                            ack_seen  <= ~sda_in;  // slave pulls low to ack
                            byte_done <= 1'b1;
                            state     <= eeprom_ctrl_pkg::EN_IDLE;
                        end
                        default: ;
                    endcase
                end
                default: state <= eeprom_ctrl_pkg::EN_IDLE;
            endcase
        end
    end

    // msb first in both directions
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_ctrl_pkg::EN_IDLE && byte_go)
        begin
            shreg <= byte_cmd.tx_byte;
        end
        else if (state == eeprom_ctrl_pkg::EN_BITS && phase == eeprom_bus_pkg::PH_SAMPLE)
        begin
            shreg <= {shreg[eeprom_bus_pkg::DATA_W-2:0], rd_mode & sda_in};
        end
    end

endmodule

//--- design/eeprom_seq.sv
`timescale 1ns/1ps

module eeprom_seq (
    input  logic                         CLK,
    input  logic                         RESET,
    input  eeprom_bus_pkg::eeprom_cmd_t  cmd,
    input  logic                         cmd_valid,
    output logic                         cmd_done,
    output eeprom_ctrl_pkg::byte_cmd_t   byte_cmd,
    output logic                         byte_go,
    input  logic                         byte_busy,
    input  logic                         byte_done,
    input  logic                         ack_seen,
    input  eeprom_bus_pkg::eeprom_data_t rx_byte,
    output eeprom_bus_pkg::eeprom_data_t rdata,
    output logic                         ack,
    output logic                         nack,
    output logic                         busy
);

    eeprom_ctrl_pkg::seq_state_e state;
    eeprom_ctrl_pkg::seq_state_e state_nx;
    logic                        abort;
    logic                        abort_nx;
    logic                        sent_byte;

    // states whose byte wants a slave ack
    assign sent_byte = state inside {eeprom_ctrl_pkg::ST_CTRL_W, eeprom_ctrl_pkg::ST_ADDR,
                                     eeprom_ctrl_pkg::ST_DATA_W, eeprom_ctrl_pkg::ST_CTRL_R};

    // next op goes out in the same cycle as byte_done
    always_comb
    begin
        state_nx         = state;
        abort_nx         = abort;
        byte_go          = 1'b0;
        byte_cmd.op      = eeprom_ctrl_pkg::OP_STOP;
        byte_cmd.tx_byte = '0;
        byte_cmd.last    = 1'b0;
        if (byte_done && sent_byte && !ack_seen)
        begin
            byte_go  = 1'b1;        // no ack, bail out with a stop
            abort_nx = 1'b1;
            state_nx = eeprom_ctrl_pkg::ST_STOP;
        end
        else
        begin
            case (state)
                eeprom_ctrl_pkg::ST_IDLE:
                    if (cmd_valid && !byte_busy)
                    begin
                        byte_go     = 1'b1;
                        byte_cmd.op = eeprom_ctrl_pkg::OP_START;
                        abort_nx    = 1'b0;
                        state_nx    = eeprom_ctrl_pkg::ST_START;
                    end
                eeprom_ctrl_pkg::ST_START:
                    if (byte_done)
                    begin
                        byte_go          = 1'b1;
                        byte_cmd.op      = eeprom_ctrl_pkg::OP_WRITE;
                        byte_cmd.tx_byte = eeprom_bus_pkg::ctrl_byte(cmd.addr,
                                                                     eeprom_bus_pkg::RW_WRITE);
                        state_nx         = eeprom_ctrl_pkg::ST_CTRL_W;
                    end
                eeprom_ctrl_pkg::ST_CTRL_W:
                    if (byte_done)
                    begin
                        byte_go          = 1'b1;
                        byte_cmd.op      = eeprom_ctrl_pkg::OP_WRITE;
                        byte_cmd.tx_byte = cmd.addr[eeprom_bus_pkg::DATA_W-1:0];  // low address
                        state_nx         = eeprom_ctrl_pkg::ST_ADDR;
                    end
                eeprom_ctrl_pkg::ST_ADDR:
                    if (byte_done && cmd.is_read)
                    begin
                        byte_go     = 1'b1;
                        byte_cmd.op = eeprom_ctrl_pkg::OP_START;
                        state_nx    = eeprom_ctrl_pkg::ST_RESTART;
                    end
                    else if (byte_done)
                    begin
                        byte_go          = 1'b1;
                        byte_cmd.op      = eeprom_ctrl_pkg::OP_WRITE;
                        byte_cmd.tx_byte = cmd.wdata;
                        state_nx         = eeprom_ctrl_pkg::ST_DATA_W;
                    end
                eeprom_ctrl_pkg::ST_RESTART:
                    if (byte_done)
                    begin
                        byte_go          = 1'b1;
                        byte_cmd.op      = eeprom_ctrl_pkg::OP_WRITE;
                        byte_cmd.tx_byte = eeprom_bus_pkg::ctrl_byte(cmd.addr,
                                                                     eeprom_bus_pkg::RW_READ);
                        state_nx         = eeprom_ctrl_pkg::ST_CTRL_R;
                    end
                eeprom_ctrl_pkg::ST_CTRL_R:
                    if (byte_done)
                    begin
                        byte_go       = 1'b1;
                        byte_cmd.op   = eeprom_ctrl_pkg::OP_READ;
                        byte_cmd.last = 1'b1;      // single byte, master nack
                        state_nx      = eeprom_ctrl_pkg::ST_DATA_R;
                    end
                eeprom_ctrl_pkg::ST_DATA_W, eeprom_ctrl_pkg::ST_DATA_R:
                    if (byte_done)
                    begin
                        byte_go  = 1'b1;
                        state_nx = eeprom_ctrl_pkg::ST_STOP;
                    end
                eeprom_ctrl_pkg::ST_STOP:
                    if (byte_done)
                    begin
                        state_nx = eeprom_ctrl_pkg::ST_DONE;
                    end
                default: state_nx = eeprom_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= eeprom_ctrl_pkg::ST_IDLE;
            abort <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            abort <= abort_nx;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_ctrl_pkg::ST_DATA_R && byte_done)
        begin
            rdata <= rx_byte;
        end
    end

    assign cmd_done = (state == eeprom_ctrl_pkg::ST_DONE);
    assign ack      = cmd_done & ~abort;
    assign nack     = cmd_done & abort;
    assign busy     = cmd_valid | (state != eeprom_ctrl_pkg::ST_IDLE);

endmodule

//--- design/eeprom_wr.sv
`timescale 1ns/1ps

module eeprom_wr (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         wr,
    input  logic                         rd,
    input  eeprom_bus_pkg::eeprom_addr_t addr,
    input  eeprom_bus_pkg::eeprom_data_t wdata,
    output eeprom_bus_pkg::eeprom_data_t rdata,
    output logic                         ack,
    output logic                         nack,
    output logic                         busy,
    output logic                         scl,
    inout  wire                          sda
);

    eeprom_bus_pkg::eeprom_cmd_t  cmd;
    logic                         cmd_valid;
    logic                         cmd_done;
    eeprom_ctrl_pkg::byte_cmd_t   byte_cmd;
    logic                         byte_go;
    logic                         byte_busy;
    logic                         byte_done;
    logic                         ack_seen;
    eeprom_bus_pkg::eeprom_data_t rx_byte;
    logic                         sda_low;

    eeprom_cmd_latch u_latch (.*);

    eeprom_seq u_seq (.*);

    i2c_byte_engine u_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .byte_cmd  (byte_cmd),
        .byte_go   (byte_go),
        .byte_busy (byte_busy),
        .byte_done (byte_done),
        .ack_seen  (ack_seen),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda)            // pad value, pull-up sits outside
    );

    assign sda = sda_low ? 1'b0 : 1'bz;   // open drain

endmodule

//--- tests/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    output logic error,
    output int   txn_count
);

    localparam logic [3:0] DEV_CODE   = 4'b1010;
    localparam logic [2:0] ABSENT_BLK = 3'd7;

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic        drive_low;
    logic        in_frame;
    logic        cond;          // start or stop seen during this scl high
    logic        sending;
    logic        send_next;
    logic        reading;
    logic        acked;
    logic        bit_val;
    logic        sda_q;
    int          bit_idx;       // 8 is the ack slot
    int          byte_idx;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        error     = 1'b0;
        txn_count = 0;
        drive_low = 1'b0;
        in_frame  = 1'b0;
        cond      = 1'b0;
        sending   = 1'b0;
        send_next = 1'b0;
        ptr       = '0;
        bit_idx   = 0;
        byte_idx  = 0;
        for (int i = 0; i < 2048; i++)
        begin
            mem[i] = 8'(i ^ (i >> 3));  // block bits fold into the top
        end
    end

    // ack decision for a byte from the master
    task automatic accept_byte();
        acked = 1'b1;
        if (byte_idx == 0)
        begin
            if (shreg[7:4] != DEV_CODE || (shreg[0] && shreg[3:1] != ptr[10:8]))
            begin
                error = 1'b1;
            end
            ptr[10:8] = shreg[3:1];
            reading   = shreg[0];
            acked     = (shreg[3:1] != ABSENT_BLK);
            send_next = shreg[0] & acked;
            tx        = mem[ptr];
        end
        else if (byte_idx == 1 && !reading)
        begin
            ptr[7:0] = shreg;
        end
        else if (byte_idx == 2 && !reading)
        begin
            mem[ptr] = shreg;
        end
        else
        begin
            error = 1'b1;   // page write
            acked = 1'b0;
        end
        byte_idx  = byte_idx + 1;
        drive_low = acked;
    endtask

    // start and stop are sda edges with scl high
    always @(sda)
    begin
        if (scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            if (in_frame && bit_idx != 0)
            begin
                error = 1'b1;
            end
            in_frame  = 1'b1;
            cond      = 1'b1;
            bit_idx   = 0;
            byte_idx  = 0;
            sending   = 1'b0;
            send_next = 1'b0;
        end
        else if (scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            if (!in_frame || bit_idx != 0)
            begin
                error = 1'b1;
            end
            in_frame  = 1'b0;
            cond      = 1'b1;
            txn_count = txn_count + 1;
        end
        sda_q = sda;
    end

    always @(posedge scl)
    begin
        bit_val = sda;
        cond    = 1'b0;
    end

    always @(negedge scl)
    begin
        if (in_frame && !cond)
        begin
            if (bit_idx < 8)
            begin
                shreg   = {shreg[6:0], bit_val};
                bit_idx = bit_idx + 1;
                if (bit_idx == 8 && !sending)
                begin
                    accept_byte();
                end
                else if (bit_idx == 8)
                begin
                    drive_low = 1'b0;   // master ack slot
                end
                else
                begin
                    drive_low = sending & ~tx[7 - bit_idx];
                end
            end
            else
            begin
                if (sending && !bit_val)
                begin
                    error = 1'b1;       // master asked for a sequential read
                end
                bit_idx   = 0;
                sending   = send_next;
                send_next = 1'b0;
                drive_low = sending & ~tx[7];
            end
        end
    end

endmodule

//--- tests/eeprom_wr_asserts.sv
`timescale 1ns/1ps

module eeprom_wr_asserts (
    input logic                         CLK,
    input logic                         RESET,
    input logic                         wr,
    input logic                         rd,
    input eeprom_bus_pkg::eeprom_addr_t addr,
    input eeprom_bus_pkg::eeprom_data_t rdata,
    input logic                         ack,
    input logic                         nack,
    input logic                         busy,
    input logic                         scl,
    input logic                         sda
);

    int   err_cnt = 0;
    logic take;
    logic absent;

    assign take   = (wr | rd) & ~busy;
    assign absent = (addr[10:8] == 3'd7);   // block the model leaves out

    task automatic count_failure(input string what);
        $error("%s", what);
        err_cnt++;
    endtask

    reset_state: assert property (@(posedge CLK)
        $fell(RESET) |-> scl && sda && !busy && !ack && !nack)
        else count_failure("bus or status lines not idle after reset");

    idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> scl && sda && !ack && !nack)
        else count_failure("bus active or pulse seen while not busy");

    // start 4 + three bytes 3*36 + stop 4, plus latch and done cycles
    write_time: assert property (@(posedge CLK) disable iff (RESET)
        take && wr && !absent |=> (busy && !ack && !nack) [*117] ##1 (ack && busy))
        else count_failure("write did not ack 118 cycles after its strobe");

    read_time: assert property (@(posedge CLK) disable iff (RESET)
        take && !wr && !absent |=> (busy && !ack && !nack) [*157] ##1 (ack && busy))
        else count_failure("read did not ack 158 cycles after its strobe");

    absent_nack: assert property (@(posedge CLK) disable iff (RESET)
        take && absent |=> (busy && !ack && !nack) [*45] ##1 (nack && busy))
        else count_failure("refused control byte did not end in a nack");

    end_state: assert property (@(posedge CLK) disable iff (RESET)
        (ack || nack) |-> scl && sda && !(ack && nack))
        else count_failure("bus not released at the end or ack and nack together");

    rdata_hold: assert property (@(posedge CLK) disable iff (RESET)
        $changed(rdata) |-> busy)
        else count_failure("rdata changed outside a transaction");

endmodule

bind eeprom_wr eeprom_wr_asserts u_asserts (.*);

//--- tests/eeprom_wr_tb.sv
`timescale 1ns/1ps

module eeprom_wr_tb;

    localparam int N_PAIRS = 12;
    localparam int N_TXN   = 2 * N_PAIRS + 2;   // two more into the absent block
    localparam int MAX_CYC = N_TXN * 160 + 200;

    logic                         CLK;
    logic                         RESET;
    logic                         wr;
    logic                         rd;
    eeprom_bus_pkg::eeprom_addr_t addr;
    eeprom_bus_pkg::eeprom_data_t wdata;
    eeprom_bus_pkg::eeprom_data_t rdata;
    logic                         ack;
    logic                         nack;
    logic                         busy;
    logic                         scl;
    wire                          sda;
    logic                         model_err;
    int                           model_txns;
    eeprom_bus_pkg::eeprom_data_t ref_mem [0:2047];
    eeprom_bus_pkg::eeprom_addr_t written [$];
    int                           seed = 62;
    int                           cycles = 0;
    int                           accepted = 0;

    pullup (sda);

    eeprom_wr dut0 (.*);

    eeprom_model model0 (
        .scl       (scl),
        .sda       (sda),
        .error     (model_err),
        .txn_count (model_txns)
    );

    always #20 CLK = ~CLK;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(negedge CLK)
    begin
        cycles = cycles + 1;
        if (dut0.u_asserts.err_cnt != 0)
        begin
            stop_run("an assertion on the DUT failed");
        end
        else if (model_err)
        begin
            stop_run("the EEPROM model saw a start, stop or framing error");
        end
        else if (cycles > MAX_CYC)
        begin
            stop_run("timeout, the transactions did not finish in time");
        end
    end

    // strobe, optional strobes while busy, wait for the end pulse
    task automatic run_txn(input logic is_rd, input eeprom_bus_pkg::eeprom_addr_t a,
                           input eeprom_bus_pkg::eeprom_data_t d, input logic poke);
        logic absent;
        absent = (a[10:8] == 3'd7);
        @(posedge CLK);
        #1;
        wr       = ~is_rd;
        rd       = is_rd;
        addr     = a;
        wdata    = d;
        accepted = accepted + 1;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        if (poke)
        begin
            repeat (9) @(posedge CLK);
            #1;
            wr   = 1'b1;
            rd   = 1'b1;
            addr = ~a;
            @(posedge CLK);
            #1;
            wr = 1'b0;
            rd = 1'b0;
        end
        do
            @(negedge CLK);
        while (!ack && !nack);
        assert (ack == !absent)
            else stop_run($sformatf("[FAIL] %0t ack expected %0b actual %0b",
                                    $time, !absent, ack));
        assert (nack == absent)
            else stop_run($sformatf("[FAIL] %0t nack expected %0b actual %0b",
                                    $time, absent, nack));
        if (is_rd && !absent)
        begin
            assert (rdata == ref_mem[a])
                else stop_run($sformatf("[FAIL] %0t rdata expected %02h actual %02h",
                                        $time, ref_mem[a], rdata));
        end
        else if (!absent)
        begin
            ref_mem[a] = d;
        end
    endtask

    initial
    begin
        eeprom_bus_pkg::eeprom_addr_t a;
        eeprom_bus_pkg::eeprom_data_t d;
        CLK   = 1'b0;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (4) @(posedge CLK);
        for (int i = 0; i < N_PAIRS; i++)
        begin
            a = {3'($unsigned($random(seed)) % 7), 8'($random(seed))};
            d = 8'($random(seed));
            written.push_back(a);
            run_txn(1'b0, a, d, i == 2);
        end
        // absent block at a written low byte leaves the memory alone
        run_txn(1'b0, {3'd7, written[0][7:0]}, 8'hc3, 1'b0);
        run_txn(1'b1, {3'd7, written[1][7:0]}, 8'h00, 1'b1);
        foreach (written[i])
        begin
            run_txn(1'b1, written[i], 8'h00, i == 5);
        end
        repeat (2) @(negedge CLK);
        if (dut0.u_asserts.err_cnt != 0 || model_err)
        begin
            stop_run("an error was flagged in the last cycles of the run");
        end
        else if (model_txns != accepted)
        begin
            stop_run($sformatf("[FAIL] %0t txn_count expected %0d actual %0d",
                               $time, accepted, model_txns));
        end
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- eeprom_wr.f
design/eeprom_bus_pkg.sv
design/eeprom_ctrl_pkg.sv
design/eeprom_cmd_latch.sv
design/i2c_byte_engine.sv
design/eeprom_seq.sv
design/eeprom_wr.sv
tests/eeprom_model.sv
tests/eeprom_wr_asserts.sv
tests/eeprom_wr_tb.sv
